// File: src/hdmi_aux_pkg.sv
package hdmi_aux_pkg;

  localparam int AUX_POS_W  = 16;
  localparam int AUX_DATA_W = 9;
  localparam int AUX_WORD_W = AUX_POS_W + AUX_DATA_W;
  localparam int LINE_W     = 10;

  // position counted from the first blanking cycle of a line.
  typedef logic [AUX_POS_W-1:0] aux_pos_t;

  typedef logic [AUX_DATA_W-1:0] aux_data_t;

  // position in the upper bits, payload in the lower bits.
  typedef logic [AUX_WORD_W-1:0] aux_word_t;

  typedef logic [LINE_W-1:0] line_t;

  typedef enum logic [2:0] {
    WAIT_PKT,
    LOAD,
    WAIT_LINE,
    WAIT_POS,
    BURST
  } sched_state_t;

  // start position field of an aux word.
  function automatic aux_pos_t aux_pos_of(aux_word_t word);
    return word[AUX_WORD_W-1:AUX_DATA_W];
  endfunction

  // payload field of an aux word.
  function automatic aux_data_t aux_data_of(aux_word_t word);
    return word[AUX_DATA_W-1:0];
  endfunction

endpackage

// File: src/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
  parameter int H_ACTIVE = 64,
  parameter int H_TOTAL  = 160,
  parameter int V_TOTAL  = 8
) (
  input  logic                   pclk,
  input  logic                   rst,
  output logic                   vde,
  output hdmi_aux_pkg::line_t    line,
  output hdmi_aux_pkg::aux_pos_t blank_pos
);

  import hdmi_aux_pkg::*;

  localparam int HCNT_W = $clog2(H_TOTAL);

  logic [HCNT_W-1:0] hcnt;
  logic [HCNT_W-1:0] hcnt_nxt;
  logic              h_wrap;
  logic              v_wrap;
  logic              active_nxt;

  assign h_wrap     = (hcnt == HCNT_W'(H_TOTAL - 1));
  assign v_wrap     = (line == line_t'(V_TOTAL - 1));
  assign hcnt_nxt   = h_wrap ? '0 : hcnt + 1'b1;
  assign active_nxt = (hcnt_nxt < HCNT_W'(H_ACTIVE));

  // horizontal and vertical counters.
  always_ff @(posedge pclk) begin
    if (rst) begin
      hcnt <= '0;
      line <= '0;
    end else begin
      hcnt <= hcnt_nxt;
      if (h_wrap) begin
        if (v_wrap) begin
          line <= '0;
        end else begin
          line <= line + 1'b1;
        end
      end
    end
  end

  // decoded from the next count so both outputs line up with hcnt.
  // count 0 is the first active pixel, so vde starts high.
  always_ff @(posedge pclk) begin
    if (rst) begin
      vde       <= 1'b1;
      blank_pos <= '0;
    end else begin
      vde <= active_nxt;
      if (active_nxt) begin
        blank_pos <= '0;
      end else begin
        blank_pos <= aux_pos_t'(hcnt_nxt) - aux_pos_t'(H_ACTIVE);
      end
    end
  end

endmodule

// File: src/aux_ingress.sv
`timescale 1ns/1ps

module aux_ingress (
  input  logic                    pclk,
  input  logic                    rst,
  input  logic                    req,
  output logic                    ack,
  input  hdmi_aux_pkg::aux_word_t word_in,
  input  logic                    full,
  output logic                    wr_en,
  output hdmi_aux_pkg::aux_word_t wr_data
);

  typedef enum logic {
    IDLE,
    HOLD
  } ingress_state_t;

  ingress_state_t state;
  logic           accept;

  // take a word only on a fresh req with room in the FIFO.
  assign accept = (state == IDLE) && req && !full;

  // ack stays up until the host drops req.
  assign ack = (state == HOLD);

  always_ff @(posedge pclk) begin
    if (rst) begin
      state <= IDLE;
      wr_en <= 1'b0;
    end else begin
      wr_en <= accept;
      case (state)
        IDLE: begin
          if (accept) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (!req) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  // word is stable while req is high.
  always_ff @(posedge pclk) begin
    if (accept) begin
      wr_data <= word_in;
    end
  end

endmodule

// File: src/aux_fifo.sv
`timescale 1ns/1ps

module aux_fifo #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                         pclk,
  input  logic                         rst,
  input  logic                         wr_en,
  input  hdmi_aux_pkg::aux_word_t      wr_data,
  input  logic                         rd_en,
  output hdmi_aux_pkg::aux_word_t      rd_data,
  output logic                         full,
  output logic [$clog2(FIFO_DEPTH):0]  count
);

  import hdmi_aux_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  aux_word_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  always_ff @(posedge pclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge pclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // show-ahead head word.
  assign rd_data = mem[rd_ptr];
  assign full    = (count == (PTR_W + 1)'(FIFO_DEPTH));

  a_no_overflow: assert property (@(posedge pclk) disable iff (rst)
    wr_en |-> !full);

  a_no_underflow: assert property (@(posedge pclk) disable iff (rst)
    rd_en |-> (count != '0));

endmodule

// File: src/aux_scheduler.sv
`timescale 1ns/1ps

module aux_scheduler #(
  parameter int AUX_BURST = 32,
  parameter int CNT_W     = 7
) (
  input  logic                    pclk,
  input  logic                    rst,
  input  logic                    vde,
  input  hdmi_aux_pkg::line_t     line,
  input  hdmi_aux_pkg::aux_pos_t  blank_pos,
  input  hdmi_aux_pkg::line_t     aux_line,
  input  logic [CNT_W-1:0]        count,
  input  hdmi_aux_pkg::aux_word_t rd_data,
  output logic                    rd_en,
  output logic                    ade,
  output hdmi_aux_pkg::aux_data_t aux_data
);

  import hdmi_aux_pkg::*;

  localparam int BCNT_W = $clog2(AUX_BURST + 1);

  sched_state_t      state;
  aux_pos_t          start_pos;
  aux_pos_t          next_pos;
  logic [BCNT_W-1:0] burst_cnt;
  logic              pkt_ready;
  logic              on_line;
  logic              pos_hit;
  logic              last_word;

  assign pkt_ready = (count >= CNT_W'(AUX_BURST));
  assign on_line   = (line == aux_line);

  // look one cycle ahead so ade rises exactly at start_pos.
  assign next_pos  = blank_pos + 1'b1;
  assign pos_hit   = on_line && !vde && (next_pos == start_pos);
  assign last_word = (burst_cnt == BCNT_W'(AUX_BURST - 1));

  always_ff @(posedge pclk) begin
    if (rst) begin
      state     <= WAIT_PKT;
      ade       <= 1'b0;
      burst_cnt <= '0;
    end else begin
      case (state)
        WAIT_PKT: begin
          if (pkt_ready) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          state <= WAIT_LINE;
        end
        WAIT_LINE: begin
          if (on_line) begin
            state <= WAIT_POS;
          end
        end
        WAIT_POS: begin
          if (pos_hit) begin
            state     <= BURST;
            ade       <= 1'b1;
            burst_cnt <= '0;
          end else if (!on_line) begin
            // start already passed so retry next frame.
            state <= WAIT_LINE;
          end
        end
        BURST: begin
          burst_cnt <= burst_cnt + 1'b1;
          if (last_word) begin
            state <= WAIT_PKT;
            ade   <= 1'b0;
          end
        end
        default: begin
          state <= WAIT_PKT;
          ade   <= 1'b0;
        end
      endcase
    end
  end

  // only the first word of a packet carries the position.
  always_ff @(posedge pclk) begin
    if (state == LOAD) begin
      start_pos <= aux_pos_of(rd_data);
    end
  end

  // one word per cycle straight off the FIFO head.
  assign rd_en    = (state == BURST);
  assign aux_data = ade ? aux_data_of(rd_data) : '0;

  a_ade_in_blank: assert property (@(posedge pclk) disable iff (rst)
    ade |-> !vde);

  // pops stay within a packet that count already showed.
  a_pop_in_burst: assert property (@(posedge pclk) disable iff (rst)
    rd_en |-> (count >= CNT_W'(AUX_BURST) - CNT_W'(burst_cnt)));

  a_burst_aligned: assert property (@(posedge pclk) disable iff (rst)
    $rose(ade) |-> (blank_pos == start_pos) && on_line);

endmodule

// File: src/hdmi_aux_top.sv
`timescale 1ns/1ps

module hdmi_aux_top #(
  parameter int H_ACTIVE   = 64,
  parameter int H_TOTAL    = 160,
  parameter int V_TOTAL    = 8,
  parameter int AUX_BURST  = 32,
  parameter int FIFO_DEPTH = 64
) (
  input  logic                    pclk,
  input  logic                    rst,
  input  logic                    req,
  output logic                    ack,
  input  hdmi_aux_pkg::aux_word_t word_in,
  input  hdmi_aux_pkg::line_t     aux_line,
  output logic                    vde,
  output logic                    ade,
  output hdmi_aux_pkg::aux_data_t aux_data
);

  import hdmi_aux_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

  line_t            line;
  aux_pos_t         blank_pos;
  logic             full;
  logic             wr_en;
  aux_word_t        wr_data;
  logic             rd_en;
  aux_word_t        rd_data;
  logic [CNT_W-1:0] count;

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL)
  ) i_video_timing (
    .pclk      (pclk),
    .rst       (rst),
    .vde       (vde),
    .line      (line),
    .blank_pos (blank_pos)
  );

  aux_ingress i_aux_ingress (
    .pclk    (pclk),
    .rst     (rst),
    .req     (req),
    .ack     (ack),
    .word_in (word_in),
    .full    (full),
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  aux_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_aux_fifo (
    .pclk    (pclk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .full    (full),
    .count   (count)
  );

  aux_scheduler #(
    .AUX_BURST (AUX_BURST),
    .CNT_W     (CNT_W)
  ) i_aux_scheduler (
    .pclk      (pclk),
    .rst       (rst),
    .vde       (vde),
    .line      (line),
    .blank_pos (blank_pos),
    .aux_line  (aux_line),
    .count     (count),
    .rd_data   (rd_data),
    .rd_en     (rd_en),
    .ade       (ade),
    .aux_data  (aux_data)
  );

endmodule

// File: test/tb_hdmi_aux_top.sv
`timescale 1ns/1ps

module tb_hdmi_aux_top;

  import hdmi_aux_pkg::*;

  localparam int H_ACTIVE   = 64;
  localparam int H_TOTAL    = 160;
  localparam int V_TOTAL    = 8;
  localparam int AUX_BURST  = 32;
  localparam int FIFO_DEPTH = 64;
  localparam int NUM_TESTS  = 4;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 3 * H_TOTAL * V_TOTAL;
  // a normal handshake waits one cycle for ack.
  localparam int STALL_CYCLES = 4;

  // stimulus table, one column per test.
  string t_name  [NUM_TESTS] = '{"single_packet", "two_same_line", "frame_wrap",
                                 "back_pressure"};
  int    t_line  [NUM_TESTS] = '{3, 5, 0, 6};
  int    t_wait  [NUM_TESTS] = '{-1, -1, 6, 1};
  int    t_npkt  [NUM_TESTS] = '{1, 2, 1, 3};
  int    t_start [NUM_TESTS][3] = '{'{4, 0, 0}, '{4, 50, 0}, '{10, 0, 0}, '{4, 50, 20}};
  int    t_seed  [NUM_TESTS] = '{1, 2, 3, 4};
  bit    t_stall [NUM_TESTS] = '{0, 0, 0, 1};

  logic      pclk;
  logic      rst;
  logic      req;
  logic      ack;
  aux_word_t word_in;
  line_t     aux_line;
  logic      vde;
  logic      ade;
  aux_data_t aux_data;

  int          mh = 0;
  int          ml = 0;
  int          cycles = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          passed = 0;
  int          failed = 0;
  int          cur_line = 0;
  bit          stall_seen = 0;
  string       cur_name = "reset";
  logic [31:0] rng;
  aux_data_t   exp_data [$];
  int          exp_off [$];
  int          exp_line [$];

  hdmi_aux_top #(
    .H_ACTIVE   (H_ACTIVE),
    .H_TOTAL    (H_TOTAL),
    .V_TOTAL    (V_TOTAL),
    .AUX_BURST  (AUX_BURST),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_hdmi_aux_top (
    .pclk     (pclk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .word_in  (word_in),
    .aux_line (aux_line),
    .vde      (vde),
    .ade      (ade),
    .aux_data (aux_data)
  );

  always #2 pclk = ~pclk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic value_error(input string what, input int exp_v, input int act_v);
    note_error($sformatf("Fail %s %s: expected %0d, actual %0d", cur_name, what, exp_v, act_v));
  endtask

  // reference timing, hcnt 0 of line 0 on the first cycle out of reset.
  always @(posedge pclk) begin
    if (rst) begin
      mh <= 0;
      ml <= 0;
    end else if (mh == H_TOTAL - 1) begin
      mh <= 0;
      ml <= (ml == V_TOTAL - 1) ? 0 : ml + 1;
    end else begin
      mh <= mh + 1;
    end
  end

  always @(posedge pclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles: no burst seen in test %s", cycles, cur_name);
      $display("Result: FAILED");
      $finish;
    end
  end

  // outputs are stable at the falling edge.
  always @(negedge pclk) begin
    aux_data_t e_data;
    int        e_off;
    int        e_line;
    if (!rst) begin
      assert (vde == (mh < H_ACTIVE))
        else value_error("vde", int'(mh < H_ACTIVE), int'(vde));
      assert (!(ade && vde))
        else note_error($sformatf("ade high during active video in test %s", cur_name));
      if (ade) begin
        assert (exp_data.size() != 0)
          else note_error($sformatf("ade high with no word queued in test %s", cur_name));
        if (exp_data.size() != 0) begin
          e_data = exp_data.pop_front();
          e_off  = exp_off.pop_front();
          e_line = exp_line.pop_front();
          assert (ml == e_line) else value_error("line", e_line, ml);
          assert (mh - H_ACTIVE == e_off) else value_error("offset", e_off, mh - H_ACTIVE);
          assert (aux_data == e_data) else value_error("aux_data", int'(e_data), int'(aux_data));
        end
      end else begin
        assert (aux_data == '0) else value_error("idle aux_data", 0, int'(aux_data));
      end
    end
  end

  // four-phase master side.
  task automatic send_word(input aux_word_t w);
    int waited;
    waited = 0;
    @(posedge pclk);
    req     <= 1'b1;
    word_in <= w;
    @(posedge pclk);
    while (!ack) begin
      waited++;
      @(posedge pclk);
    end
    req <= 1'b0;
    @(posedge pclk);
    while (ack) begin
      @(posedge pclk);
    end
    if (waited > STALL_CYCLES) begin
      stall_seen = 1;
    end
  endtask

  task automatic send_packet(input int start);
    aux_word_t words [AUX_BURST];
    aux_data_t d;
    aux_pos_t  pos;
    for (int k = 0; k < AUX_BURST; k++) begin
      rng = xorshift(rng);
      d   = rng[8:0];
      pos = (k == 0) ? aux_pos_t'(start) : aux_pos_t'(0);
      words[k] = {pos, d};
      exp_data.push_back(d);
      exp_off.push_back(start + k);
      exp_line.push_back(cur_line);
    end
    for (int k = 0; k < AUX_BURST; k++) begin
      send_word(words[k]);
    end
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      $display("test %s: ok", cur_name);
      passed++;
    end else begin
      $display("test %s: %0d errors", cur_name, test_errors);
      failed++;
    end
  endtask

  task automatic run_test(input int i);
    cur_name    = t_name[i];
    test_errors = 0;
    stall_seen  = 0;
    repeat (t_seed[i]) rng = xorshift(rng);
    if (t_wait[i] >= 0) begin
      while (ml != t_wait[i]) begin
        @(posedge pclk);
      end
    end
    @(posedge pclk);
    aux_line <= line_t'(t_line[i]);
    cur_line = t_line[i];
    for (int p = 0; p < t_npkt[i]; p++) begin
      send_packet(t_start[i][p]);
    end
    while (exp_data.size() != 0) begin
      @(posedge pclk);
    end
    assert (!t_stall[i] || stall_seen)
      else note_error($sformatf("ack never stalled on a full FIFO in test %s", cur_name));
    report_test();
  endtask

  initial begin
    int n;
    pclk     = 1'b0;
    rst      = 1'b1;
    req      = 1'b0;
    word_in  = '0;
    aux_line = '0;
    rng      = 32'h816c;
    repeat (4) @(posedge pclk);
    rst <= 1'b0;
    @(negedge pclk);
    assert (ack == 1'b0) else value_error("ack", 0, int'(ack));
    assert (ade == 1'b0) else value_error("ade", 0, int'(ade));
    assert (aux_data == '0) else value_error("aux_data", 0, int'(aux_data));
    n = 0;
    while (vde) begin
      n++;
      @(negedge pclk);
    end
    assert (n == H_ACTIVE) else value_error("vde high cycles", H_ACTIVE, n);
    report_test();
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", passed + failed, passed,
             failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: hdmi_aux_top.f
src/hdmi_aux_pkg.sv
src/video_timing.sv
src/aux_ingress.sv
src/aux_fifo.sv
src/aux_scheduler.sv
src/hdmi_aux_top.sv
test/tb_hdmi_aux_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_hdmi_aux_top -f hdmi_aux_top.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^Result: PASSED$'; then
  exit 0
fi
echo "pass message not found"
exit 1
